// ==== alloc_sequencer.sv ====
`timescale 1ns/1ps

module alloc_sequencer (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               req_valid_i,
  input  logic                               req_is_alloc_i,
  input  logic [heap_layout_pkg::DATA_W-1:0] req_size_i,
  input  logic [heap_layout_pkg::DATA_W-1:0] req_addr_i,
  output logic                               req_ready_o,
  output logic                               res_valid_o,
  output logic [heap_layout_pkg::DATA_W-1:0] res_addr_o,
  input  logic                               res_ready_i,
  output logic                               store_req_valid_o,
  output heap_bus_pkg::store_op_e            store_op_o,
  output heap_layout_pkg::header_t           store_header_o,
  input  logic                               store_rsp_valid_i,
  input  heap_layout_pkg::header_t           store_rsp_header_i,
  output heap_layout_pkg::header_t           fit_header_o,
  output heap_layout_pkg::header_t           prev_header_o,
  output logic [heap_layout_pkg::DATA_W-1:0] alloc_size_o,
  input  logic                               do_split_i,
  input  heap_layout_pkg::header_t           alloc_header_i,
  input  heap_layout_pkg::header_t           remainder_header_i,
  input  heap_layout_pkg::header_t           fit_link_header_i,
  output heap_layout_pkg::header_t           curr_header_o,
  output heap_layout_pkg::header_t           target_header_o,
  output heap_layout_pkg::header_t           right_header_o,
  output logic [heap_layout_pkg::DATA_W-1:0] free_addr_o,
  input  heap_bus_pkg::free_merge_e          merge_i,
  input  heap_layout_pkg::header_t           merged_header_i,
  input  heap_layout_pkg::header_t           free_link_header_i
);
  import heap_layout_pkg::*;
  import heap_bus_pkg::*;

  seq_state_e        state_q;
  logic              is_alloc_q;
  logic [DATA_W-1:0] size_q;
  logic [DATA_W-1:0] addr_q;
  header_t           curr_q;
  header_t           prev_q;
  header_t           target_q;
  header_t           right_q;
  logic              fits;
  logic              in_gap;

  assign req_ready_o = (state_q == IDLE);
  assign res_valid_o = (state_q == RESULT);

  assign fit_header_o    = curr_q;
  assign prev_header_o   = prev_q;
  assign alloc_size_o    = size_q;
  assign curr_header_o   = curr_q;
  assign target_header_o = target_q;
  assign right_header_o  = right_q;
  assign free_addr_o     = addr_q;

  assign fits   = (curr_q.addr != LIST_HEAD_ADDR) && (curr_q.size >= size_q);  // First fit
  assign in_gap = (curr_q.addr < addr_q) &&
                  ((curr_q.next_addr == '0) || (addr_q < curr_q.next_addr));

  // ==================================================
  // List walk and header updates
  // ==================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q           <= IDLE;
      store_req_valid_o <= 1'b0;
      res_addr_o        <= '0;
    end else begin
      store_req_valid_o <= 1'b0;  // One request in flight at most
      unique case (state_q)
        IDLE: begin
          if (req_valid_i) begin
            is_alloc_q        <= req_is_alloc_i;
            size_q            <= req_size_i;
            addr_q            <= req_addr_i;
            res_addr_o        <= '0;
            store_req_valid_o <= 1'b1;
            store_op_o        <= LOAD;
            store_header_o    <= '{addr: LIST_HEAD_ADDR, default: '0};
            state_q           <= SEARCH_WAIT;
          end
        end
        SEARCH_WAIT: begin
          if (store_rsp_valid_i) begin
            prev_q  <= curr_q;
            curr_q  <= store_rsp_header_i;
            state_q <= is_alloc_q ? ALLOC_CHECK : FREE_CHECK;
          end
        end
        ALLOC_CHECK: begin
          if (fits) begin
            store_req_valid_o <= 1'b1;
            store_op_o        <= WRITE_SIZE_NEXT;
            store_header_o    <= alloc_header_i;
            res_addr_o        <= curr_q.addr;
            state_q           <= FIT_WAIT;
          end else if (curr_q.next_addr == '0) begin
            state_q <= RESULT;  // Nothing large enough
          end else begin
            store_req_valid_o <= 1'b1;
            store_op_o        <= LOAD;
            store_header_o    <= '{addr: curr_q.next_addr, default: '0};
            state_q           <= SEARCH_WAIT;
          end
        end
        FIT_WAIT: begin
          if (store_rsp_valid_i) begin
            store_req_valid_o <= 1'b1;
            if (do_split_i) begin
              store_op_o     <= WRITE_SIZE_NEXT;
              store_header_o <= remainder_header_i;
              state_q        <= SPLIT_WAIT;
            end else begin
              store_op_o     <= WRITE_NEXT;
              store_header_o <= fit_link_header_i;
              state_q        <= LINK_WAIT;
            end
          end
        end
        SPLIT_WAIT: begin
          if (store_rsp_valid_i) begin
            store_req_valid_o <= 1'b1;
            store_op_o        <= WRITE_NEXT;
            store_header_o    <= fit_link_header_i;
            state_q           <= LINK_WAIT;
          end
        end
        FREE_CHECK: begin
          if (in_gap) begin
            store_req_valid_o <= 1'b1;
            store_op_o        <= LOAD;
            store_header_o    <= '{addr: addr_q, default: '0};
            state_q           <= TARGET_WAIT;
          end else if (curr_q.next_addr == '0) begin
            state_q <= RESULT;  // Address not behind any free block
          end else begin
            store_req_valid_o <= 1'b1;
            store_op_o        <= LOAD;
            store_header_o    <= '{addr: curr_q.next_addr, default: '0};
            state_q           <= SEARCH_WAIT;
          end
        end
        TARGET_WAIT: begin
          if (store_rsp_valid_i) begin
            target_q <= store_rsp_header_i;
            state_q  <= MERGE_CHECK;
          end
        end
        MERGE_CHECK: begin
          if ((merge_i == RIGHT) || (merge_i == BOTH)) begin
            store_req_valid_o <= 1'b1;
            store_op_o        <= LOAD;
            store_header_o    <= '{addr: curr_q.next_addr, default: '0};
            state_q           <= RIGHT_WAIT;
          end else begin
            state_q <= MERGE_WRITE;
          end
        end
        RIGHT_WAIT: begin
          if (store_rsp_valid_i) begin
            right_q <= store_rsp_header_i;
            state_q <= MERGE_WRITE;
          end
        end
        MERGE_WRITE: begin
          store_req_valid_o <= 1'b1;
          store_op_o        <= WRITE_SIZE_NEXT;
          store_header_o    <= merged_header_i;
          state_q           <= MERGE_WAIT;
        end
        MERGE_WAIT: begin
          if (store_rsp_valid_i) begin
            if ((merge_i == NONE) || (merge_i == RIGHT)) begin
              store_req_valid_o <= 1'b1;
              store_op_o        <= WRITE_NEXT;
              store_header_o    <= free_link_header_i;
              state_q           <= LINK_WAIT;
            end else begin
              state_q <= RESULT;  // Left block already absorbed it
            end
          end
        end
        LINK_WAIT: begin
          if (store_rsp_valid_i) begin
            state_q <= RESULT;
          end
        end
        RESULT: begin
          if (res_ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

// ==== coalesce_calc.sv ====
`timescale 1ns/1ps

module coalesce_calc (
  input  heap_layout_pkg::header_t           curr_header_i,
  input  heap_layout_pkg::header_t           target_header_i,
  input  heap_layout_pkg::header_t           right_header_i,
  input  logic [heap_layout_pkg::DATA_W-1:0] free_addr_i,
  output heap_bus_pkg::free_merge_e          merge_o,
  output heap_layout_pkg::header_t           merged_header_o,
  output heap_layout_pkg::header_t           link_header_o
);
  import heap_layout_pkg::*;
  import heap_bus_pkg::*;

  logic [DATA_W-1:0] free_end;
  logic [DATA_W-1:0] curr_end;
  logic              touch_left;
  logic              touch_right;

  assign free_end    = free_addr_i + BLOCK_HEADER_SIZE + target_header_i.size;
  assign curr_end    = curr_header_i.addr + BLOCK_HEADER_SIZE + curr_header_i.size;
  assign touch_right = (curr_header_i.next_addr != '0) && (free_end == curr_header_i.next_addr);
  assign touch_left  = (curr_header_i.addr != LIST_HEAD_ADDR) && (curr_end == free_addr_i);

  always_comb begin
    if (touch_left && touch_right) begin
      merge_o = BOTH;
    end else if (touch_left) begin
      merge_o = LEFT;
    end else if (touch_right) begin
      merge_o = RIGHT;
    end else begin
      merge_o = NONE;
    end
  end

  always_comb begin
    // Plain insert unless a neighbour absorbs the block
    merged_header_o.addr      = free_addr_i;
    merged_header_o.size      = target_header_i.size;
    merged_header_o.next_addr = curr_header_i.next_addr;
    unique case (merge_o)
      LEFT: begin
        merged_header_o.addr = curr_header_i.addr;
        merged_header_o.size = curr_header_i.size + BLOCK_HEADER_SIZE + target_header_i.size;
      end
      RIGHT: begin
        merged_header_o.size      = target_header_i.size + BLOCK_HEADER_SIZE + right_header_i.size;
        merged_header_o.next_addr = right_header_i.next_addr;
      end
      BOTH: begin
        merged_header_o.addr      = curr_header_i.addr;
        merged_header_o.size      = curr_header_i.size + target_header_i.size + right_header_i.size
                                    + BLOCK_HEADER_SIZE + BLOCK_HEADER_SIZE;
        merged_header_o.next_addr = right_header_i.next_addr;
      end
      default: ;
    endcase
  end

  // Previous block must point at the freed block for NONE and RIGHT
  always_comb begin
    link_header_o           = curr_header_i;
    link_header_o.next_addr = free_addr_i;
  end

endmodule

// ==== fit_split_calc.sv ====
`timescale 1ns/1ps

module fit_split_calc (
  input  heap_layout_pkg::header_t           fit_header_i,
  input  heap_layout_pkg::header_t           prev_header_i,
  input  logic [heap_layout_pkg::DATA_W-1:0] alloc_size_i,
  output logic                               do_split_o,
  output heap_layout_pkg::header_t           alloc_header_o,
  output heap_layout_pkg::header_t           remainder_header_o,
  output heap_layout_pkg::header_t           link_header_o
);
  import heap_layout_pkg::*;

  logic [DATA_W-1:0] rest;

  assign rest       = fit_header_i.size - alloc_size_i;
  assign do_split_o = (fit_header_i.size >= alloc_size_i) &&
                      (rest >= BLOCK_HEADER_SIZE + MIN_ALLOC_SIZE);

  always_comb begin
    alloc_header_o.addr      = fit_header_i.addr;
    alloc_header_o.size      = do_split_o ? alloc_size_i : fit_header_i.size;
    alloc_header_o.next_addr = '0;  // Taken block leaves the list

    // Remainder sits right after the allocated payload
    remainder_header_o.addr      = fit_header_i.addr + BLOCK_HEADER_SIZE + alloc_size_i;
    remainder_header_o.size      = rest - BLOCK_HEADER_SIZE;
    remainder_header_o.next_addr = fit_header_i.next_addr;

    link_header_o           = prev_header_i;
    link_header_o.next_addr = do_split_o ? remainder_header_o.addr : fit_header_i.next_addr;
  end

endmodule

// ==== header_store.sv ====
`timescale 1ns/1ps

module header_store (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     store_req_valid_i,
  input  heap_bus_pkg::store_op_e  store_op_i,
  input  heap_layout_pkg::header_t store_header_i,
  output logic                     store_rsp_valid_o,
  output heap_layout_pkg::header_t store_rsp_header_o
);
  import heap_layout_pkg::*;
  import heap_bus_pkg::*;

  logic [DATA_W-1:0]     size_mem [STORE_DEPTH];
  logic [DATA_W-1:0]     next_mem [STORE_DEPTH];
  logic [DATA_W-1:0]     offset;
  logic [SLOT_IDX_W-1:0] slot;

  assign offset = store_header_i.addr - LIST_HEAD_ADDR;
  assign slot   = offset[SLOT_SHIFT +: SLOT_IDX_W];  // 8-byte slot index

  // ==================================================
  // Header memory with free-list reset image
  // ==================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < STORE_DEPTH; i++) begin
        size_mem[i] <= '0;
        next_mem[i] <= '0;
      end
      next_mem[0]         <= HEAP_BASE;  // Sentinel points at the one big block
      size_mem[HEAP_SLOT] <= HEAP_BYTES - BLOCK_HEADER_SIZE;
    end else if (store_req_valid_i) begin
      if (store_op_i == WRITE_SIZE_NEXT) begin
        size_mem[slot] <= store_header_i.size;
      end
      if (store_op_i != LOAD) begin
        next_mem[slot] <= store_header_i.next_addr;
      end
    end
  end

  // ==================================================
  // Registered response
  // ==================================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      store_rsp_valid_o <= 1'b0;
    end else begin
      store_rsp_valid_o <= store_req_valid_i;
    end
  end

  // Reports the header as it stands after the request
  always_ff @(posedge clk_i) begin
    if (store_req_valid_i) begin
      store_rsp_header_o.addr <= store_header_i.addr;
      store_rsp_header_o.size <= (store_op_i == WRITE_SIZE_NEXT) ? store_header_i.size
                                                                  : size_mem[slot];
      store_rsp_header_o.next_addr <= (store_op_i == LOAD) ? next_mem[slot]
                                                           : store_header_i.next_addr;
    end
  end

endmodule

// ==== heap_alloc_tb.sv ====
`timescale 1ns/1ps

module heap_alloc_tb;
  import heap_layout_pkg::*;

  localparam int WAIT_LIMIT = 200;  // Cycles per wait before giving up
  localparam logic [DATA_W-1:0] FULL_SIZE = HEAP_BYTES - BLOCK_HEADER_SIZE;

  typedef struct packed {
    logic              do_reset;  // Pulse reset before this row
    logic              is_alloc;
    logic [DATA_W-1:0] arg;       // Size for allocate, header address for free
    logic [DATA_W-1:0] exp_addr;
    logic [7:0]        stall;     // Cycles res_ready_i is held low
  } op_row_t;

  logic              clk;
  logic              rst_n;
  logic              req_valid;
  logic              req_is_alloc;
  logic [DATA_W-1:0] req_size;
  logic [DATA_W-1:0] req_addr;
  logic              req_ready;
  logic              res_valid;
  logic [DATA_W-1:0] res_addr;
  logic              res_ready;

  op_row_t ops[$];
  int      checks;
  int      value_errors;
  int      timeout_errors;
  logic    aborted;

  heap_alloc_top dut_i (
    .clk_i(clk), .rst_ni(rst_n),
    .req_valid_i(req_valid), .req_is_alloc_i(req_is_alloc),
    .req_size_i(req_size), .req_addr_i(req_addr), .req_ready_o(req_ready),
    .res_valid_o(res_valid), .res_addr_o(res_addr), .res_ready_i(res_ready)
  );

  always #50 clk = ~clk;

  // ==================================================
  // Checks
  // ==================================================
  task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("[ERROR] t=%0t %s expected 'h%h actual 'h%h", $time, name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    checks++;
    assert (actual === expected) else begin
      $display("[ERROR] t=%0t %s expected %b actual %b", $time, name, expected, actual);
      value_errors++;
    end
  endtask

  // ==================================================
  // Stimulus table
  // ==================================================
  task automatic add_row(input logic do_reset, input logic is_alloc,
                         input logic [DATA_W-1:0] arg, input logic [DATA_W-1:0] exp_addr,
                         input logic [7:0] stall);
    op_row_t row;
    row.do_reset = do_reset;
    row.is_alloc = is_alloc;
    row.arg      = arg;
    row.exp_addr = exp_addr;
    row.stall    = stall;
    ops.push_back(row);
  endtask

  task automatic build_table();
    add_row(1'b0, 1'b1, 16'd32, 16'h0020, 8'd0);  // Split, remainder 0x48 size 208
    add_row(1'b0, 1'b1, 16'd16, 16'h0048, 8'd2);  // Remainder 0x60 size 184
    add_row(1'b0, 1'b1, 16'd48, 16'h0060, 8'd0);  // Remainder 0x98 size 128
    add_row(1'b0, 1'b1, 16'd200, 16'h0000, 8'd0); // Larger than any free block
    add_row(1'b0, 1'b1, 16'd16, 16'h0098, 8'd3);  // Remainder 0xb0 size 104
    add_row(1'b0, 1'b0, 16'h0048, 16'h0000, 8'd0); // No neighbour is free
    add_row(1'b0, 1'b1, 16'd16, 16'h0048, 8'd0);  // Exact fit, no split
    add_row(1'b0, 1'b0, 16'h0098, 16'h0000, 8'd0); // Right merge with 0xb0
    add_row(1'b0, 1'b0, 16'h0020, 16'h0000, 8'd0); // Plain insert
    add_row(1'b0, 1'b0, 16'h0048, 16'h0000, 8'd0); // Left merge into 0x20
    add_row(1'b0, 1'b0, 16'h0060, 16'h0000, 8'd1); // Both sides merge
    add_row(1'b0, 1'b1, FULL_SIZE, HEAP_BASE, 8'd0);  // Whole heap is one block again
    add_row(1'b0, 1'b1, 16'd16, 16'h0000, 8'd0);  // Free list is empty
    add_row(1'b1, 1'b1, FULL_SIZE, HEAP_BASE, 8'd2);
    add_row(1'b0, 1'b1, 16'd8, 16'h0000, 8'd0);
  endtask

  // ==================================================
  // Reset, waits and one request
  // ==================================================
  task automatic apply_reset();
    @(posedge clk);
    rst_n     <= 1'b0;
    req_valid <= 1'b0;
    res_ready <= 1'b0;
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
    end
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("req_ready_o", 1'b1, req_ready);
    check_flag("res_valid_o", 1'b0, res_valid);
    check_flag("store_req_valid", 1'b0, dut_i.store_req_valid);
  endtask

  task automatic wait_req_ready();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!req_ready && (cycles < WAIT_LIMIT)) begin
      @(negedge clk);
      cycles++;
    end
    if (!req_ready) begin
      $display("Timeout: req_ready_o stayed low for %0d cycles", WAIT_LIMIT);
      timeout_errors++;
      aborted = 1'b1;
    end
  endtask

  task automatic wait_res_valid();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!res_valid && (cycles < WAIT_LIMIT)) begin
      @(negedge clk);
      cycles++;
    end
    if (!res_valid) begin
      $display("Timeout: no result came back within %0d cycles", WAIT_LIMIT);
      timeout_errors++;
      aborted = 1'b1;
    end
  endtask

  task automatic run_op(input op_row_t row);
    logic [DATA_W-1:0] held;
    wait_req_ready();
    if (!aborted) begin
      @(posedge clk);
      req_valid    <= 1'b1;
      req_is_alloc <= row.is_alloc;
      req_size     <= row.is_alloc ? row.arg : '0;
      req_addr     <= row.is_alloc ? '0 : row.arg;
      @(posedge clk);  // Request taken here, ready was high
      req_valid <= 1'b0;
      wait_res_valid();
    end
    if (!aborted) begin
      check_value("res_addr_o", row.exp_addr, res_addr);
      held = res_addr;
      for (int i = 0; i < row.stall; i++) begin
        @(negedge clk);
        check_flag("res_valid_o", 1'b1, res_valid);
        check_value("res_addr_o", held, res_addr);
        check_flag("req_ready_o", 1'b0, req_ready);
      end
      @(posedge clk);
      res_ready <= 1'b1;
      @(posedge clk);
      res_ready <= 1'b0;
      @(negedge clk);
      check_flag("res_valid_o", 1'b0, res_valid);
    end
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    req_valid      = 1'b0;
    req_is_alloc   = 1'b0;
    req_size       = '0;
    req_addr       = '0;
    res_ready      = 1'b0;
    checks         = 0;
    value_errors   = 0;
    timeout_errors = 0;
    aborted        = 1'b0;

    build_table();
    apply_reset();
    for (int r = 0; r < ops.size(); r++) begin
      if (aborted) begin
        break;
      end
      if (ops[r].do_reset) begin
        apply_reset();
      end
      run_op(ops[r]);
    end

    $display("Summary: %0d checks, %0d value errors, %0d timeouts",
             checks, value_errors, timeout_errors);
    if ((value_errors == 0) && (timeout_errors == 0)) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== heap_alloc_top.sv ====
`timescale 1ns/1ps

module heap_alloc_top (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               req_valid_i,
  input  logic                               req_is_alloc_i,
  input  logic [heap_layout_pkg::DATA_W-1:0] req_size_i,
  input  logic [heap_layout_pkg::DATA_W-1:0] req_addr_i,
  output logic                               req_ready_o,
  output logic                               res_valid_o,
  output logic [heap_layout_pkg::DATA_W-1:0] res_addr_o,
  input  logic                               res_ready_i
);
  import heap_layout_pkg::*;
  import heap_bus_pkg::*;

  logic              store_req_valid;
  store_op_e         store_op;
  header_t           store_header;
  logic              store_rsp_valid;
  header_t           store_rsp_header;

  // Fit calculator
  header_t           fit_header;
  header_t           prev_header;
  logic [DATA_W-1:0] alloc_size;
  logic              do_split;
  header_t           alloc_header;
  header_t           remainder_header;
  header_t           fit_link_header;

  // Coalesce calculator
  header_t           curr_header;
  header_t           target_header;
  header_t           right_header;
  logic [DATA_W-1:0] free_addr;
  free_merge_e       merge;
  header_t           merged_header;
  header_t           free_link_header;

  alloc_sequencer seq_i (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .req_valid_i(req_valid_i), .req_is_alloc_i(req_is_alloc_i),
    .req_size_i(req_size_i), .req_addr_i(req_addr_i), .req_ready_o(req_ready_o),
    .res_valid_o(res_valid_o), .res_addr_o(res_addr_o), .res_ready_i(res_ready_i),
    .store_req_valid_o(store_req_valid), .store_op_o(store_op),
    .store_header_o(store_header),
    .store_rsp_valid_i(store_rsp_valid), .store_rsp_header_i(store_rsp_header),
    .fit_header_o(fit_header), .prev_header_o(prev_header), .alloc_size_o(alloc_size),
    .do_split_i(do_split), .alloc_header_i(alloc_header),
    .remainder_header_i(remainder_header), .fit_link_header_i(fit_link_header),
    .curr_header_o(curr_header), .target_header_o(target_header),
    .right_header_o(right_header), .free_addr_o(free_addr),
    .merge_i(merge), .merged_header_i(merged_header),
    .free_link_header_i(free_link_header)
  );

  fit_split_calc fit_i (
    .fit_header_i(fit_header), .prev_header_i(prev_header), .alloc_size_i(alloc_size),
    .do_split_o(do_split), .alloc_header_o(alloc_header),
    .remainder_header_o(remainder_header), .link_header_o(fit_link_header)
  );

  coalesce_calc coalesce_i (
    .curr_header_i(curr_header), .target_header_i(target_header),
    .right_header_i(right_header), .free_addr_i(free_addr),
    .merge_o(merge), .merged_header_o(merged_header), .link_header_o(free_link_header)
  );

  header_store store_i (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .store_req_valid_i(store_req_valid), .store_op_i(store_op),
    .store_header_i(store_header),
    .store_rsp_valid_o(store_rsp_valid), .store_rsp_header_o(store_rsp_header)
  );

endmodule

// ==== heap_bus_pkg.sv ====
package heap_bus_pkg;

  typedef enum logic [1:0] {
    LOAD            = 2'd0,
    WRITE_SIZE_NEXT = 2'd1,  // Full header rewrite
    WRITE_NEXT      = 2'd2   // Link update only
  } store_op_e;

  // ==================================================
  // Sequencer states
  // ==================================================
  typedef enum logic [3:0] {
    IDLE,
    SEARCH_WAIT,
    ALLOC_CHECK,
    FIT_WAIT,
    SPLIT_WAIT,
    FREE_CHECK,
    TARGET_WAIT,
    MERGE_CHECK,
    RIGHT_WAIT,
    MERGE_WRITE,
    MERGE_WAIT,
    LINK_WAIT,
    RESULT
  } seq_state_e;

  typedef enum logic [1:0] {
    NONE,
    LEFT,
    RIGHT,
    BOTH
  } free_merge_e;

endpackage

// ==== heap_layout_pkg.sv ====
package heap_layout_pkg;

  // ==================================================
  // Heap address map and sizes
  // ==================================================
  localparam int DATA_W = 16;

  localparam logic [DATA_W-1:0] BLOCK_HEADER_SIZE = 16'd8;
  localparam logic [DATA_W-1:0] MIN_ALLOC_SIZE    = 16'd16;

  localparam logic [DATA_W-1:0] LIST_HEAD_ADDR = 16'h0010;  // Sentinel, size 0
  localparam logic [DATA_W-1:0] HEAP_BASE      = 16'h0020;
  localparam logic [DATA_W-1:0] HEAP_BYTES     = 16'd256;

  // One slot per 8 bytes from the sentinel up to the heap end
  localparam int STORE_DEPTH = 34;
  localparam int SLOT_SHIFT  = $clog2(BLOCK_HEADER_SIZE);
  localparam int SLOT_IDX_W  = $clog2(STORE_DEPTH);
  localparam int HEAP_SLOT   = (HEAP_BASE - LIST_HEAD_ADDR) / BLOCK_HEADER_SIZE;

  // ==================================================
  // Block header
  // ==================================================
  typedef struct packed {
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] size;
    logic [DATA_W-1:0] next_addr;  // Zero ends the list
  } header_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module heap_alloc_tb -o heap_alloc_sim

./obj_dir/heap_alloc_sim | tee sim.log

if grep -q "^Test passed$" sim.log; then
  echo "Simulation result: PASS"
  exit 0
else
  echo "Simulation result: FAIL"
  exit 1
fi

// ==== vlog.f ====
heap_layout_pkg.sv
heap_bus_pkg.sv
header_store.sv
fit_split_calc.sv
coalesce_calc.sv
alloc_sequencer.sv
heap_alloc_top.sv
heap_alloc_tb.sv
